// ==== common/vlsu_pkg.sv ====
package vlsu_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    localparam int VLEN       = 64;
    localparam int VLENB      = VLEN / 8;
    localparam int XLEN       = 32;
    localparam int NBYTES     = XLEN / 8;
    localparam int ELEM_IDX_W = $clog2(VLENB);

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    // Element width, value is log2 of the byte count
    typedef enum logic [1:0] {
        EW8  = 2'b00,
        EW16 = 2'b01,
        EW32 = 2'b10
    } vew_e;

    typedef enum logic {
        VOP_LOAD  = 1'b0,
        VOP_STORE = 1'b1
    } vop_e;

    typedef enum logic {
        AM_STRIDED = 1'b0,
        AM_INDEXED = 1'b1
    } addr_mode_e;

    typedef enum logic [1:0] {
        S_IDLE  = 2'b00,
        S_EXEC  = 2'b01,
        S_DRAIN = 2'b10
    } vlsu_state_e;

    ////////////////////////////////////////////////////////////
    // Command and memory request
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        vop_e            op;
        addr_mode_e      mode;
        vew_e            width;
        logic [XLEN-1:0] base;
        // Two's complement byte stride
        logic [XLEN-1:0] stride;
    } vlsu_cmd_t;

    typedef struct packed {
        logic [XLEN-1:0]   addr;
        logic              re;
        logic [NBYTES-1:0] we;
        logic [XLEN-1:0]   wdata;
    } mem_req_t;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    // 8, 4 or 2 elements per register
    function automatic logic [ELEM_IDX_W:0] elems_per_reg(input vew_e w);
        return (ELEM_IDX_W + 1)'(VLENB >> w);
    endfunction

    // 1, 2 or 4 bytes per element
    function automatic logic [2:0] elem_bytes(input vew_e w);
        return 3'(1 << w);
    endfunction

    // Element k of a register, zero-extended
    function automatic logic [XLEN-1:0] elem_select(
        input logic [VLEN-1:0]       vec,
        input logic [ELEM_IDX_W-1:0] k,
        input vew_e                  w
    );
        logic [XLEN-1:0] elem;
        elem = '0;
        unique case (w)
            EW8:     elem[7:0]  = vec[8*k +: 8];
            EW16:    elem[15:0] = vec[16*k[1:0] +: 16];
            default: elem       = vec[32*k[0] +: 32];
        endcase
        return elem;
    endfunction

endpackage

// ==== logic/vlsu_sequencer.sv ====
module vlsu_sequencer (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            start_i,
    input  vlsu_pkg::vlsu_cmd_t             cmd_i,
    output vlsu_pkg::vlsu_cmd_t             cmd_o,
    output logic                            issue_o,
    output logic [vlsu_pkg::ELEM_IDX_W-1:0] elem_idx_o,
    output logic                            busy_o,
    output logic                            done_o
);
    import vlsu_pkg::*;

    vlsu_state_e           state_q;
    vlsu_cmd_t             cmd_q;
    logic [ELEM_IDX_W-1:0] cnt_q;
    logic [ELEM_IDX_W-1:0] last_idx;
    logic                  done_q;
    logic                  accept;
    logic                  last_elem;

    // Busy also covers the done cycle
    assign busy_o    = (state_q != S_IDLE) || done_q;
    assign accept    = start_i && !busy_o;
    assign last_idx  = ELEM_IDX_W'(elems_per_reg(cmd_q.width) - 1'b1);
    assign last_elem = (cnt_q == last_idx);

    // Lanes see the new command already on the start cycle
    assign cmd_o      = accept ? cmd_i : cmd_q;
    assign issue_o    = (state_q == S_EXEC);
    assign elem_idx_o = cnt_q;
    assign done_o     = done_q;

    ////////////////////////////////////////////////////////////
    // Operation FSM and element counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= S_IDLE;
            cmd_q   <= '0;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            // One drain cycle for the last load word before done
            done_q <= (state_q == S_DRAIN);
            unique case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        state_q <= S_EXEC;
                        cmd_q   <= cmd_i;
                        cnt_q   <= '0;
                    end
                end
                S_EXEC: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_elem) begin
                        state_q <= S_DRAIN;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Starts during an operation are dropped
    start_while_busy_a: assert property (
        @(posedge clk) disable iff (!reset_n) start_i |-> !busy_o
    ) else $warning("vlsu_sequencer: start ignored while busy");

    // Only the three defined element widths are taken
    legal_width_a: assert property (
        @(posedge clk) disable iff (!reset_n)
        accept |-> cmd_i.width inside {EW8, EW16, EW32}
    );

endmodule

// ==== logic/vlsu_addr_gen.sv ====
module vlsu_addr_gen (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            start_i,
    input  vlsu_pkg::vlsu_cmd_t             cmd_i,
    input  logic [vlsu_pkg::VLEN-1:0]       index_i,
    input  logic                            issue_i,
    input  logic [vlsu_pkg::ELEM_IDX_W-1:0] elem_idx_i,
    output logic [vlsu_pkg::XLEN-1:0]       addr_o
);
    import vlsu_pkg::*;

    logic [VLEN-1:0] index_q;
    logic [XLEN-1:0] stride_off_q;
    logic [XLEN-1:0] index_off;
    logic [XLEN-1:0] offset;

    // Index vector held for the whole operation
    always_ff @(posedge clk) begin
        if (start_i) begin
            index_q <= index_i;
        end
    end

    // Running k times stride
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            stride_off_q <= '0;
        end else if (start_i) begin
            stride_off_q <= '0;
        end else if (issue_i) begin
            stride_off_q <= stride_off_q + cmd_i.stride;
        end
    end

    assign index_off = elem_select(index_q, elem_idx_i, cmd_i.width);
    assign offset    = (cmd_i.mode == AM_INDEXED) ? index_off : stride_off_q;
    assign addr_o    = cmd_i.base + offset;

    // Command holds steady while elements issue
    cmd_stable_a: assert property (
        @(posedge clk) disable iff (!reset_n)
        issue_i ##1 issue_i |-> $stable(cmd_i)
    );

endmodule

// ==== datapath/vlsu_store_lane.sv ====
module vlsu_store_lane (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            start_i,
    input  vlsu_pkg::vlsu_cmd_t             cmd_i,
    input  logic [vlsu_pkg::VLEN-1:0]       store_data_i,
    input  logic                            issue_i,
    input  logic [vlsu_pkg::ELEM_IDX_W-1:0] elem_idx_i,
    input  logic [vlsu_pkg::XLEN-1:0]       addr_i,
    output vlsu_pkg::mem_req_t              mem_req_o
);
    import vlsu_pkg::*;

    logic [VLEN-1:0]   data_q;
    logic [XLEN-1:0]   elem;
    logic [XLEN-1:0]   wdata;
    logic [NBYTES-1:0] base_mask;
    logic [NBYTES-1:0] byte_mask;

    always_ff @(posedge clk) begin
        if (start_i) begin
            data_q <= store_data_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Lane replication
    ////////////////////////////////////////////////////////////

    assign elem = elem_select(data_q, elem_idx_i, cmd_i.width);

    // Same element on every lane, the mask picks the live one
    always_comb begin
        unique case (cmd_i.width)
            EW8:     wdata = {4{elem[7:0]}};
            EW16:    wdata = {2{elem[15:0]}};
            default: wdata = elem;
        endcase
    end

    // Element-sized run of ones moved to the byte offset
    assign base_mask = NBYTES'((1 << elem_bytes(cmd_i.width)) - 1);
    assign byte_mask = base_mask << addr_i[1:0];

    ////////////////////////////////////////////////////////////
    // Memory request
    ////////////////////////////////////////////////////////////

    assign mem_req_o.addr  = addr_i;
    assign mem_req_o.re    = issue_i && (cmd_i.op == VOP_LOAD);
    assign mem_req_o.we    = (issue_i && cmd_i.op == VOP_STORE) ? byte_mask : '0;
    assign mem_req_o.wdata = wdata;

    // Half-words and words must not cross a word
    natural_align_a: assert property (
        @(posedge clk) disable iff (!reset_n)
        issue_i |-> (cmd_i.width == EW8)
                 || (cmd_i.width == EW16 && addr_i[0] == 1'b0)
                 || (cmd_i.width == EW32 && addr_i[1:0] == 2'b00)
    );

endmodule

// ==== datapath/vlsu_load_lane.sv ====
module vlsu_load_lane (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            start_i,
    input  vlsu_pkg::vlsu_cmd_t             cmd_i,
    input  logic                            issue_i,
    input  logic [vlsu_pkg::ELEM_IDX_W-1:0] elem_idx_i,
    input  logic [vlsu_pkg::XLEN-1:0]       addr_i,
    input  logic [vlsu_pkg::XLEN-1:0]       mem_rdata_i,
    output logic [vlsu_pkg::VLEN-1:0]       read_data_o
);
    import vlsu_pkg::*;

    logic                  rd_valid_q;
    logic [1:0]            rd_off_q;
    logic [ELEM_IDX_W-1:0] rd_idx_q;
    vew_e                  rd_width_q;
    logic [XLEN-1:0]       lane;
    logic [VLEN-1:0]       result_q;

    ////////////////////////////////////////////////////////////
    // Stage 2 register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= issue_i && (cmd_i.op == VOP_LOAD);
        end
    end

    // Where the returning word goes
    always_ff @(posedge clk) begin
        if (issue_i) begin
            rd_off_q   <= addr_i[1:0];
            rd_idx_q   <= elem_idx_i;
            rd_width_q <= cmd_i.width;
        end
    end

    ////////////////////////////////////////////////////////////
    // Lane extraction
    ////////////////////////////////////////////////////////////

    always_comb begin
        lane = '0;
        unique case (rd_width_q)
            EW8:     lane[7:0]  = mem_rdata_i[8*rd_off_q +: 8];
            EW16:    lane[15:0] = rd_off_q[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];
            default: lane       = mem_rdata_i;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Result register
    ////////////////////////////////////////////////////////////

    // Stores leave the previous result in place
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_q <= '0;
        end else if (start_i && cmd_i.op == VOP_LOAD) begin
            result_q <= '0;
        end else if (rd_valid_q) begin
            unique case (rd_width_q)
                EW8:     result_q[8*rd_idx_q +: 8]        <= lane[7:0];
                EW16:    result_q[16*rd_idx_q[1:0] +: 16] <= lane[15:0];
                default: result_q[32*rd_idx_q[0] +: 32]   <= lane;
            endcase
        end
    end

    assign read_data_o = result_q;

endmodule

// ==== logic/vlsu_top.sv ====
module vlsu_top (
    input  logic                      clk,
    input  logic                      reset_n,

    input  logic                      start_i,
    input  vlsu_pkg::vlsu_cmd_t       cmd_i,
    input  logic [vlsu_pkg::VLEN-1:0] index_i,
    input  logic [vlsu_pkg::VLEN-1:0] store_data_i,

    output logic                      busy_o,
    output logic                      done_o,
    output logic [vlsu_pkg::VLEN-1:0] read_data_o,

    output vlsu_pkg::mem_req_t        mem_req_o,
    input  logic [vlsu_pkg::XLEN-1:0] mem_rdata_i
);
    import vlsu_pkg::*;

    vlsu_cmd_t             cmd;
    logic                  start_acc;
    logic                  issue;
    logic [ELEM_IDX_W-1:0] elem_idx;
    logic [XLEN-1:0]       addr;

    // Lanes only latch on starts that the sequencer takes
    assign start_acc = start_i && !busy_o;

    vlsu_sequencer vlsu_sequencer_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .start_i    (start_i),
        .cmd_i      (cmd_i),
        .cmd_o      (cmd),
        .issue_o    (issue),
        .elem_idx_o (elem_idx),
        .busy_o     (busy_o),
        .done_o     (done_o)
    );

    vlsu_addr_gen vlsu_addr_gen_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .start_i    (start_acc),
        .cmd_i      (cmd),
        .index_i    (index_i),
        .issue_i    (issue),
        .elem_idx_i (elem_idx),
        .addr_o     (addr)
    );

    vlsu_store_lane vlsu_store_lane_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start_acc),
        .cmd_i        (cmd),
        .store_data_i (store_data_i),
        .issue_i      (issue),
        .elem_idx_i   (elem_idx),
        .addr_i       (addr),
        .mem_req_o    (mem_req_o)
    );

    vlsu_load_lane vlsu_load_lane_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .start_i     (start_acc),
        .cmd_i       (cmd),
        .issue_i     (issue),
        .elem_idx_i  (elem_idx),
        .addr_i      (addr),
        .mem_rdata_i (mem_rdata_i),
        .read_data_o (read_data_o)
    );

endmodule

// ==== tb/tb_vlsu.sv ====
module tb_vlsu;
    import vlsu_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_OPS    = 9;
    localparam int OP_CYCLES  = 20;
    // Ten times the longest run of all operations, plus reset and setup
    localparam int TIMEOUT_CYCLES = 10 * NUM_OPS * OP_CYCLES + 200;

    logic            clk;
    logic            reset_n;
    logic            start_i;
    vlsu_cmd_t       cmd_i;
    logic [VLEN-1:0] index_i;
    logic [VLEN-1:0] store_data_i;
    logic            busy_o;
    logic            done_o;
    logic [VLEN-1:0] read_data_o;
    mem_req_t        mem_req_o;
    logic [XLEN-1:0] mem_rdata_i;

    logic [7:0]  mem [256];
    logic [7:0]  mirror [256];
    int          errors      = 0;
    int          cycle_count = 0;
    logic [31:0] lcg_state   = 32'd26695;
    // Result register as the model sees it after the last load
    logic [63:0] last_load_exp;

    vlsu_top vlsu_top_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start_i),
        .cmd_i        (cmd_i),
        .index_i      (index_i),
        .store_data_i (store_data_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .read_data_o  (read_data_o),
        .mem_req_o    (mem_req_o),
        .mem_rdata_i  (mem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Memory model with one cycle read latency and byte writes
    ////////////////////////////////////////////////////////////

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_rdata_i <= '0;
        end else begin
            if (mem_req_o.re) begin
                mem_rdata_i <= {mem[{mem_req_o.addr[7:2], 2'd3}], mem[{mem_req_o.addr[7:2], 2'd2}],
                                mem[{mem_req_o.addr[7:2], 2'd1}], mem[{mem_req_o.addr[7:2], 2'd0}]};
            end
            for (int b = 0; b < NBYTES; b++) begin
                if (mem_req_o.we[b]) begin
                    mem[{mem_req_o.addr[7:2], 2'(b)}] <= mem_req_o.wdata[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, DUT never finished", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int width_bytes(input vew_e w);
        case (w)
            EW8:     return 1;
            EW16:    return 2;
            default: return 4;
        endcase
    endfunction

    function automatic vlsu_cmd_t make_cmd(input vop_e op, input addr_mode_e mode,
                                           input vew_e w, input logic [31:0] base,
                                           input logic [31:0] stride);
        vlsu_cmd_t c;
        c.op     = op;
        c.mode   = mode;
        c.width  = w;
        c.base   = base;
        c.stride = stride;
        return c;
    endfunction

    // Element k of a vector that is nbytes wide
    function automatic logic [31:0] vec_elem(input logic [63:0] vec, input int k, input int nbytes);
        logic [63:0] shifted;
        logic [31:0] mask;
        shifted = vec >> (8 * nbytes * k);
        mask    = (nbytes == 4) ? 32'hFFFF_FFFF : ((32'h1 << (8 * nbytes)) - 32'h1);
        return shifted[31:0] & mask;
    endfunction

    function automatic logic [31:0] elem_addr(input vlsu_cmd_t c, input logic [63:0] idx,
                                              input int k);
        if (c.mode == AM_INDEXED) begin
            return c.base + vec_elem(idx, k, width_bytes(c.width));
        end
        return c.base + c.stride * 32'(k);
    endfunction

    function automatic logic [63:0] expected_load(input vlsu_cmd_t c, input logic [63:0] idx);
        logic [63:0] res;
        logic [31:0] addr;
        int          nb;
        res = '0;
        nb  = width_bytes(c.width);
        for (int k = 0; k < 8 / nb; k++) begin
            addr = elem_addr(c, idx, k);
            for (int b = 0; b < nb; b++) begin
                res[8*(nb*k+b) +: 8] = mirror[8'(addr + 32'(b))];
            end
        end
        return res;
    endfunction

    function automatic void apply_store(input vlsu_cmd_t c, input logic [63:0] idx,
                                        input logic [63:0] sdata);
        logic [31:0] addr;
        logic [31:0] data;
        int          nb;
        nb = width_bytes(c.width);
        for (int k = 0; k < 8 / nb; k++) begin
            addr = elem_addr(c, idx, k);
            data = vec_elem(sdata, k, nb);
            for (int b = 0; b < nb; b++) begin
                mirror[8'(addr + 32'(b))] = data[8*b +: 8];
            end
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Drive, wait and compare
    ////////////////////////////////////////////////////////////

    task automatic check_vec(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_memory(input string name);
        for (int i = 0; i < 256; i++) begin
            if (mem[i] !== mirror[i]) begin
                errors++;
                $display("FAILED %s byte %02h: expected %h, actual %h", name, i, mirror[i], mem[i]);
            end
        end
    endtask

    // Runs one operation up to done and may inject a second start mid-run
    task automatic run_op(input string name, input vlsu_cmd_t c, input logic [63:0] idx,
                          input logic [63:0] sdata, input int inject_at,
                          output logic [63:0] result);
        int        n;
        int        cycles;
        logic      seen_done;
        vlsu_cmd_t alt;
        n        = 8 / width_bytes(c.width);
        alt      = c;
        alt.op   = (c.op == VOP_LOAD) ? VOP_STORE : VOP_LOAD;
        alt.base = c.base ^ 32'h80;
        @(posedge clk);
        start_i      <= 1'b1;
        cmd_i        <= c;
        index_i      <= idx;
        store_data_i <= sdata;
        @(posedge clk);
        start_i   <= 1'b0;
        cycles    = 0;
        seen_done = 1'b0;
        result    = '0;
        while (!seen_done) begin
            @(negedge clk);
            cycles++;
            if (!busy_o) begin
                errors++;
                $display("%s: busy_o low in cycle %0d before done", name, cycles);
            end
            if (done_o) begin
                seen_done = 1'b1;
                result    = read_data_o;
            end else begin
                @(posedge clk);
                start_i <= (cycles == inject_at);
                if (cycles == inject_at) begin
                    cmd_i <= alt;
                end
            end
        end
        if (cycles != n + 2) begin
            errors++;
            $display("FAILED %s done cycle: expected %0d, actual %0d", name, n + 2, cycles);
        end
        // Done is a single pulse and busy ends with it
        repeat (4) begin
            @(negedge clk);
            if (done_o || busy_o) begin
                errors++;
                $display("%s: done_o or busy_o high after the done cycle", name);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_ew32_load();
        vlsu_cmd_t   c;
        logic [63:0] act;
        @(negedge clk);
        if (busy_o !== 1'b0 || done_o !== 1'b0) begin
            errors++;
            $display("reset: busy_o or done_o not low after reset");
        end
        if (mem_req_o.re !== 1'b0 || mem_req_o.we !== 4'b0) begin
            errors++;
            $display("reset: memory request active after reset");
        end
        check_vec("reset_read_data", '0, read_data_o);
        c = make_cmd(VOP_LOAD, AM_STRIDED, EW32, 32'h20, 32'd4);
        run_op("ew32_unit_load", c, '0, '0, -1, act);
        check_vec("ew32_unit_load", expected_load(c, '0), act);
    endtask

    task automatic test_strided_ew8_load();
        vlsu_cmd_t   c;
        logic [63:0] act;
        c = make_cmd(VOP_LOAD, AM_STRIDED, EW8, 32'h50, 32'd3);
        run_op("ew8_stride3_load", c, '0, '0, -1, act);
        check_vec("ew8_stride3_load", expected_load(c, '0), act);
        c = make_cmd(VOP_LOAD, AM_STRIDED, EW8, 32'hA0, 32'hFFFF_FFFB);
        run_op("ew8_stride_neg5_load", c, '0, '0, -1, act);
        check_vec("ew8_stride_neg5_load", expected_load(c, '0), act);
    endtask

    task automatic test_indexed_ew16_load();
        vlsu_cmd_t   c;
        logic [63:0] idx;
        logic [63:0] act;
        for (int k = 0; k < 4; k++) begin
            idx[16*k +: 16] = 16'(lcg_next() >> 16) & 16'h007E;
        end
        c = make_cmd(VOP_LOAD, AM_INDEXED, EW16, 32'h80, 32'd0);
        run_op("ew16_indexed_load", c, idx, '0, -1, act);
        last_load_exp = expected_load(c, idx);
        check_vec("ew16_indexed_load", last_load_exp, act);
    endtask

    task automatic test_strided_stores();
        vlsu_cmd_t   c;
        logic [63:0] sdata;
        logic [63:0] prev;
        logic [63:0] act;
        prev  = last_load_exp;
        sdata = {lcg_next(), lcg_next()};
        c     = make_cmd(VOP_STORE, AM_STRIDED, EW8, 32'h10, 32'd7);
        apply_store(c, '0, sdata);
        run_op("ew8_stride7_store", c, '0, sdata, -1, act);
        check_memory("ew8_stride7_store");
        check_vec("ew8_store_read_data", prev, act);
        sdata = {lcg_next(), lcg_next()};
        c     = make_cmd(VOP_STORE, AM_STRIDED, EW16, 32'h30, 32'd6);
        apply_store(c, '0, sdata);
        run_op("ew16_stride6_store", c, '0, sdata, -1, act);
        check_memory("ew16_stride6_store");
        check_vec("ew16_store_read_data", prev, act);
    endtask

    task automatic test_indexed_store_load();
        vlsu_cmd_t   c;
        logic [31:0] idx0;
        logic [63:0] idx;
        logic [63:0] sdata;
        logic [63:0] act;
        idx0  = (lcg_next() >> 16) & 32'h3C;
        idx   = {idx0 + 32'h40, idx0};
        sdata = {lcg_next(), lcg_next()};
        c     = make_cmd(VOP_STORE, AM_INDEXED, EW32, 32'h40, 32'd0);
        apply_store(c, idx, sdata);
        run_op("ew32_indexed_store", c, idx, sdata, -1, act);
        check_memory("ew32_indexed_store");
        c.op = VOP_LOAD;
        run_op("ew32_indexed_reload", c, idx, '0, -1, act);
        check_vec("ew32_indexed_reload", sdata, act);
    endtask

    task automatic test_start_while_busy();
        vlsu_cmd_t   c;
        logic [63:0] act;
        c = make_cmd(VOP_LOAD, AM_STRIDED, EW8, 32'h08, 32'd9);
        run_op("start_while_busy", c, '0, {lcg_next(), lcg_next()}, 3, act);
        check_vec("start_while_busy", expected_load(c, '0), act);
        check_memory("start_while_busy");
    endtask

    initial begin : main_seq
        logic [31:0] word;
        reset_n      = 1'b0;
        start_i      = 1'b0;
        cmd_i        = '0;
        index_i      = '0;
        store_data_i = '0;
        for (int i = 0; i < 256; i++) begin
            word      = lcg_next();
            mem[i]    = word[23:16];
            mirror[i] = word[23:16];
        end
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        test_reset_ew32_load();
        test_strided_ew8_load();
        test_indexed_ew16_load();
        test_strided_stores();
        test_indexed_store_load();
        test_start_while_busy();

        @(negedge clk);
        $display("Run complete after %0d cycles with %0d errors", cycle_count, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
common/vlsu_pkg.sv
logic/vlsu_sequencer.sv
logic/vlsu_addr_gen.sv
datapath/vlsu_store_lane.sv
datapath/vlsu_load_lane.sv
logic/vlsu_top.sv
tb/tb_vlsu.sv

// ==== Bender.yml ====
package:
  name: vlsu

sources:
  - common/vlsu_pkg.sv
  - logic/vlsu_sequencer.sv
  - logic/vlsu_addr_gen.sv
  - datapath/vlsu_store_lane.sv
  - datapath/vlsu_load_lane.sv
  - logic/vlsu_top.sv
  - target: simulation
    files:
      - tb/tb_vlsu.sv
